// File: logic/pe_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// PE configuration word and its selector encodings
// The word is static while the PE streams, so nothing here is timed
// Selector codes NEIGH1..NEIGH3 are only live when N_NEIGH allows
//////////////////////////////////////////////////////////////////////

package pe_cfg_pkg;

  // FU opcode, DIV and REM are unsigned and multi-cycle
  typedef enum logic [2:0] {
    NOP = 3'd0,
    ADD = 3'd1,
    SUB = 3'd2,
    MUL = 3'd3,
    MIN = 3'd4,
    DIV = 3'd5,
    REM = 3'd6
  } pe_op_t;

  // Operand source for muxes A and B
  typedef enum logic [2:0] {
    NEIGH0   = 3'd0,
    NEIGH1   = 3'd1,
    NEIGH2   = 3'd2,
    NEIGH3   = 3'd3,
    SELF     = 3'd4,
    CONST    = 3'd5,
    RF_IN    = 3'd6,
    DELAY_OP = 3'd7
  } pe_mux_sel_t;

  // What the delay path forwards to the next PE
  typedef enum logic [1:0] {
    D_PE_RES      = 2'd0,
    D_PE_OP_A     = 2'd1,
    D_PE_OP_B     = 2'd2,
    D_PE_DELAY_OP = 2'd3
  } delay_src_t;

  // Register-file capture source, code 3 writes nothing
  typedef enum logic [1:0] {
    RF_STREAM = 2'd0,
    RF_OP_A   = 2'd1,
    RF_OP_B   = 2'd2
  } rf_src_t;

  typedef struct packed {
    pe_op_t      op;
    pe_mux_sel_t sel_a;
    pe_mux_sel_t sel_b;
    logic        rf_en;
    rf_src_t     rf_src;
    logic [1:0]  rf_val;     // counter value that fires a stream capture
    logic [1:0]  delay_sel;  // neighbor delay input index
    delay_src_t  delay_src;
  } pe_ctrl_t;

endpackage

// File: logic/pe_data_pkg.sv
//////////////////////////////////////////////////////////////////////
// Data-path widths and the packed stream words of the PE
// Width is fixed here since every struct below depends on it
//////////////////////////////////////////////////////////////////////

package pe_data_pkg;

  localparam int PE_DATA_W = 16;
  // Register-file capture counter
  localparam int RF_CNT_W  = 2;

  typedef logic [PE_DATA_W-1:0] pe_word_t;

  // Stream word between PEs
  typedef struct packed {
    pe_word_t data;
    logic     valid;
  } pe_stream_t;

  // Delayed operand, side bit only carried through
  typedef struct packed {
    logic     side;
    pe_word_t data;
    logic     valid;
  } pe_delay_t;

  // Write port toward the array register file
  typedef struct packed {
    logic     en;
    pe_word_t data;
  } rf_wr_t;

endpackage

// File: logic/pe_operand_select.sv
//////////////////////////////////////////////////////////////////////
// Operand muxes A and B plus the one-entry register-file write port
// N_NEIGH must be 1 to 4, missing neighbors read as invalid
// SELF is always taken as valid, CONST and RF_IN too
//////////////////////////////////////////////////////////////////////

module pe_operand_select
  import pe_cfg_pkg::*;
  import pe_data_pkg::*;
#(
  parameter int N_NEIGH = 4
) (
  input  logic                      clk_cg,
  input  logic                      rst_n_i,
  input  logic                      pea_ready_i,
  input  pe_ctrl_t                  ctrl_i,
  input  pe_stream_t [N_NEIGH-1:0]  neigh_i,
  input  pe_word_t                  const_i,
  input  pe_stream_t                self_i,
  input  pe_word_t                  rf_d_i,
  input  logic [RF_CNT_W-1:0]       rf_match_i,
  input  pe_stream_t                delay_word_i,
  output pe_stream_t                op_a_o,
  output pe_stream_t                op_b_o,
  output rf_wr_t                    rf_wr_o
);

  // Neighbors padded to the four selector codes
  pe_stream_t          neigh_pad [4];
  // Candidates indexed by pe_mux_sel_t
  pe_stream_t          cand      [8];
  logic [RF_CNT_W-1:0] rf_cnt_q;
  logic                cnt_adv;

  for (genvar i = 0; i < 4; i++) begin : g_pad
    if (i < N_NEIGH) begin : g_live
      assign neigh_pad[i] = neigh_i[i];
    end else begin : g_tied
      assign neigh_pad[i] = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Candidate vector and selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      cand[i] = neigh_pad[i];
    end
    // Own result loops back, valid forced high
    cand[SELF].data      = self_i.data;
    cand[SELF].valid     = 1'b1;
    cand[CONST].data     = const_i;
    cand[CONST].valid    = 1'b1;
    // Word echoed back from the array register file
    cand[RF_IN].data     = rf_d_i;
    cand[RF_IN].valid    = 1'b1;
    cand[DELAY_OP]       = delay_word_i;
  end

  assign op_a_o = cand[ctrl_i.sel_a];
  assign op_b_o = cand[ctrl_i.sel_b];

  //////////////////////////////////////////////////////////////////////
  // Register-file capture
  //////////////////////////////////////////////////////////////////////

  // Counts accepted NEIGH0 words while capture is on
  assign cnt_adv = ctrl_i.rf_en && pea_ready_i && neigh_pad[0].valid;

  always_ff @(posedge clk_cg or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rf_cnt_q <= '0;
    end else if (cnt_adv) begin
      // Wrap once the match value is reached
      if (rf_cnt_q == rf_match_i) begin
        rf_cnt_q <= '0;
      end else begin
        rf_cnt_q <= rf_cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    rf_wr_o = '0;
    if (ctrl_i.rf_en && pea_ready_i) begin
      case (ctrl_i.rf_src)
        RF_STREAM: begin
          rf_wr_o.en   = neigh_pad[0].valid && (rf_cnt_q == ctrl_i.rf_val);
          rf_wr_o.data = neigh_pad[0].data;
        end
        RF_OP_A: begin
          rf_wr_o.en   = op_a_o.valid;
          rf_wr_o.data = op_a_o.data;
        end
        RF_OP_B: begin
          rf_wr_o.en   = op_b_o.valid;
          rf_wr_o.data = op_b_o.data;
        end
        default: begin
          rf_wr_o = '0;
        end
      endcase
    end
  end

  // A register-file write never carries unknown data
  rf_wr_known_a: assert property (
    @(posedge clk_cg) disable iff (!rst_n_i)
    rf_wr_o.en |-> !$isunknown(rf_wr_o.data)
  );

endmodule

// File: logic/pe_divider.sv
//////////////////////////////////////////////////////////////////////
// Unsigned radix-2 restoring divider, one step per advancing cycle
// quot_o and rem_o show the result of the current step
// They are final only in the cycle where done_o is high
// Divide by zero gives all ones and the dividend as remainder
//////////////////////////////////////////////////////////////////////

module pe_divider
  import pe_data_pkg::*;
(
  input  logic     clk_cg,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  logic     pea_ready_i,
  input  logic     start_i,
  input  pe_word_t dividend_i,
  input  pe_word_t divisor_i,
  output logic     busy_o,
  output logic     done_o,
  output pe_word_t quot_o,
  output pe_word_t rem_o
);

  localparam int CNT_W = $clog2(PE_DATA_W);

  logic               busy_q;
  logic [CNT_W-1:0]   step_q;
  logic               last_step;
  // Partial remainder, dividend shifting into quotient, divisor
  pe_word_t           rem_q;
  pe_word_t           quot_q;
  pe_word_t           dvsr_q;
  // One extra bit for the shifted trial value
  logic [PE_DATA_W:0] shift_w;
  logic [PE_DATA_W:0] diff_w;
  logic               fits;

  //////////////////////////////////////////////////////////////////////
  // Shift-subtract step
  //////////////////////////////////////////////////////////////////////

  assign shift_w = {rem_q, quot_q[PE_DATA_W-1]};
  assign fits    = (shift_w >= {1'b0, dvsr_q});
  assign diff_w  = shift_w - {1'b0, dvsr_q};

  // Restore on a failed trial
  assign rem_o  = fits ? diff_w[PE_DATA_W-1:0] : shift_w[PE_DATA_W-1:0];
  assign quot_o = {quot_q[PE_DATA_W-2:0], fits};

  assign last_step = (step_q == CNT_W'(PE_DATA_W - 1));
  assign done_o    = busy_q && pea_ready_i && last_step && !flush_i;
  assign busy_o    = busy_q;

  always_ff @(posedge clk_cg or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      step_q <= '0;
      rem_q  <= '0;
      quot_q <= '0;
      dvsr_q <= '0;
    end else if (flush_i) begin
      // Abort, payload is dropped with busy
      busy_q <= 1'b0;
      step_q <= '0;
    end else if (pea_ready_i) begin
      if (start_i) begin
        busy_q <= 1'b1;
        step_q <= '0;
        rem_q  <= '0;
        quot_q <= dividend_i;
        dvsr_q <= divisor_i;
      end else if (busy_q) begin
        rem_q  <= rem_o;
        quot_q <= quot_o;
        step_q <= step_q + 1'b1;
        if (last_step) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // FU must wait for ready before issuing the next division
  div_start_busy_a: assert property (
    @(posedge clk_cg) disable iff (!rst_n_i)
    busy_o |-> !start_i
  );

endmodule

// File: logic/pe_fu.sv
//////////////////////////////////////////////////////////////////////
// Functional unit and the PE output register
// ADD SUB MUL MIN are single cycle, MUL keeps the low half
// DIV and REM hold ready_o low for PE_DATA_W advancing cycles
// NOP and flush clear the result regardless of stall
// op_i may only change together with a flush while dividing
//////////////////////////////////////////////////////////////////////

module pe_fu
  import pe_cfg_pkg::*;
  import pe_data_pkg::*;
(
  input  logic       clk_cg,
  input  logic       rst_n_i,
  input  logic       flush_i,
  input  logic       pea_ready_i,
  input  pe_op_t     op_i,
  input  pe_stream_t op_a_i,
  input  pe_stream_t op_b_i,
  output pe_stream_t res_o,
  output logic       ready_o,
  output pe_word_t   rem_o,
  output logic       fu_done_o
);

  logic                   ops_valid;
  logic                   is_div;
  logic                   div_start;
  logic                   div_busy;
  logic                   div_done;
  logic                   fu_valid;
  pe_word_t               alu_res;
  pe_word_t               div_quot;
  pe_word_t               div_rem;
  pe_word_t               fu_out;
  pe_stream_t             res_q;

  assign ops_valid = op_a_i.valid && op_b_i.valid;
  assign is_div    = (op_i == DIV) || (op_i == REM);

  // Single-cycle datapath
  always_comb begin
    case (op_i)
      ADD:     alu_res = op_a_i.data + op_b_i.data;
      SUB:     alu_res = op_a_i.data - op_b_i.data;
      // Product truncated to the word width
      MUL:     alu_res = op_a_i.data * op_b_i.data;
      MIN:     alu_res = (op_a_i.data < op_b_i.data) ? op_a_i.data : op_b_i.data;
      default: alu_res = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Divider sequencing
  //////////////////////////////////////////////////////////////////////

  // Launch on an accepted operand pair while idle
  assign div_start = is_div && ops_valid && pea_ready_i && !div_busy && !flush_i;

  pe_divider u_divider (
    .clk_cg      (clk_cg),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .pea_ready_i (pea_ready_i),
    .start_i     (div_start),
    .dividend_i  (op_a_i.data),
    .divisor_i   (op_b_i.data),
    .busy_o      (div_busy),
    .done_o      (div_done),
    .quot_o      (div_quot),
    .rem_o       (div_rem)
  );

  assign fu_valid = is_div ? div_done : ops_valid;
  assign fu_out   = !is_div ? alu_res : ((op_i == DIV) ? div_quot : div_rem);

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_cg or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_q <= '0;
    end else if (flush_i || (op_i == NOP)) begin
      res_q <= '0;
    end else if (pea_ready_i) begin
      res_q.valid <= fu_valid;
      // Data keeps the last valid result
      if (fu_valid) begin
        res_q.data <= fu_out;
      end
    end
  end

  assign res_o     = res_q;
  assign ready_o   = !div_busy;
  assign rem_o     = div_rem;
  assign fu_done_o = div_done;

  // Quotient or remainder pick relies on a steady opcode
  op_stable_div_a: assert property (
    @(posedge clk_cg) disable iff (!rst_n_i)
    (div_busy && !flush_i) |-> $stable(op_i)
  );

endmodule

// File: logic/pe_delay_path.sv
//////////////////////////////////////////////////////////////////////
// Delayed-operand forwarding toward the next PE
// One register stage, advancing only with pea_ready_i
// Side bit always comes from the selected neighbor input
// Under DIV or REM the result source carries the remainder
//////////////////////////////////////////////////////////////////////

module pe_delay_path
  import pe_cfg_pkg::*;
  import pe_data_pkg::*;
#(
  parameter int N_NEIGH = 4
) (
  input  logic                     clk_cg,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  input  logic                     pea_ready_i,
  input  logic [1:0]               delay_sel_i,
  input  delay_src_t               delay_src_i,
  input  logic                     div_op_i,
  input  pe_delay_t [N_NEIGH-1:0]  neigh_delay_i,
  input  pe_stream_t               op_a_i,
  input  pe_stream_t               op_b_i,
  input  pe_stream_t               res_i,
  input  pe_word_t                 rem_i,
  input  logic                     fu_done_i,
  output pe_stream_t               delay_word_o,
  output pe_delay_t                delay_o
);

  pe_delay_t nd_pad [4];
  pe_delay_t nd_sel;
  pe_delay_t delay_d;
  pe_delay_t delay_q;

  // Unused neighbor codes read as invalid
  for (genvar i = 0; i < 4; i++) begin : g_pad
    if (i < N_NEIGH) begin : g_live
      assign nd_pad[i] = neigh_delay_i[i];
    end else begin : g_tied
      assign nd_pad[i] = '0;
    end
  end

  assign nd_sel             = nd_pad[delay_sel_i];
  // Feeds the DELAY_OP operand candidate
  assign delay_word_o.data  = nd_sel.data;
  assign delay_word_o.valid = nd_sel.valid;

  //////////////////////////////////////////////////////////////////////
  // Source select and register
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    delay_d.side = nd_sel.side;
    case (delay_src_i)
      D_PE_RES: begin
        // Remainder leaves with the divider done pulse
        delay_d.data  = div_op_i ? rem_i : res_i.data;
        delay_d.valid = div_op_i ? fu_done_i : res_i.valid;
      end
      D_PE_OP_A: begin
        delay_d.data  = op_a_i.data;
        delay_d.valid = op_a_i.valid;
      end
      D_PE_OP_B: begin
        delay_d.data  = op_b_i.data;
        delay_d.valid = op_b_i.valid;
      end
      default: begin
        delay_d.data  = nd_sel.data;
        delay_d.valid = nd_sel.valid;
      end
    endcase
  end

  always_ff @(posedge clk_cg or negedge rst_n_i) begin
    if (!rst_n_i) begin
      delay_q <= '0;
    end else if (flush_i) begin
      delay_q <= '0;
    end else if (pea_ready_i) begin
      delay_q <= delay_d;
    end
  end

  assign delay_o = delay_q;

endmodule

// File: logic/s_pe.sv
//////////////////////////////////////////////////////////////////////
// Streaming PE with an iterative divider in its FU
// Clock arrives already gated, ctrl_i is static while streaming
// pea_ready_i low freezes every register except on flush_i
//////////////////////////////////////////////////////////////////////

module s_pe
  import pe_cfg_pkg::*;
  import pe_data_pkg::*;
#(
  parameter int N_NEIGH = 4
) (
  input  logic                     clk_cg,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  input  logic                     pea_ready_i,
  input  pe_ctrl_t                 ctrl_i,
  input  pe_stream_t [N_NEIGH-1:0] neigh_i,
  input  pe_word_t                 const_i,
  input  pe_word_t                 rf_d_i,
  input  logic [RF_CNT_W-1:0]      rf_match_i,
  input  pe_delay_t [N_NEIGH-1:0]  neigh_delay_i,
  output pe_stream_t               res_o,
  output logic                     ready_o,
  output rf_wr_t                   rf_wr_o,
  output pe_delay_t                delay_o
);

  pe_stream_t op_a;
  pe_stream_t op_b;
  pe_stream_t res;
  pe_stream_t delay_word;
  pe_word_t   rem_word;
  logic       fu_done;
  logic       div_op;

  assign div_op = (ctrl_i.op == DIV) || (ctrl_i.op == REM);
  assign res_o  = res;

  pe_operand_select #(
    .N_NEIGH (N_NEIGH)
  ) u_operand_select (
    .clk_cg       (clk_cg),
    .rst_n_i      (rst_n_i),
    .pea_ready_i  (pea_ready_i),
    .ctrl_i       (ctrl_i),
    .neigh_i      (neigh_i),
    .const_i      (const_i),
    .self_i       (res),
    .rf_d_i       (rf_d_i),
    .rf_match_i   (rf_match_i),
    .delay_word_i (delay_word),
    .op_a_o       (op_a),
    .op_b_o       (op_b),
    .rf_wr_o      (rf_wr_o)
  );

  pe_fu u_fu (
    .clk_cg      (clk_cg),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .pea_ready_i (pea_ready_i),
    .op_i        (ctrl_i.op),
    .op_a_i      (op_a),
    .op_b_i      (op_b),
    .res_o       (res),
    .ready_o     (ready_o),
    .rem_o       (rem_word),
    .fu_done_o   (fu_done)
  );

  pe_delay_path #(
    .N_NEIGH (N_NEIGH)
  ) u_delay_path (
    .clk_cg        (clk_cg),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .pea_ready_i   (pea_ready_i),
    .delay_sel_i   (ctrl_i.delay_sel),
    .delay_src_i   (ctrl_i.delay_src),
    .div_op_i      (div_op),
    .neigh_delay_i (neigh_delay_i),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .res_i         (res),
    .rem_i         (rem_word),
    .fu_done_i     (fu_done),
    .delay_word_o  (delay_word),
    .delay_o       (delay_o)
  );

endmodule

// File: testbench/tb_pe_ref.svh
//////////////////////////////////////////////////////////////////////
// Reference rules for the PE, included inside the testbench module
// Needs pe_cfg_pkg and pe_data_pkg imported by the includer
// DIV and REM are unsigned, divide by zero gives ones and dividend
//////////////////////////////////////////////////////////////////////

`ifndef TB_PE_REF_SVH
`define TB_PE_REF_SVH

// Expected FU word for one operand pair
function automatic pe_word_t ref_fu(input pe_op_t op, input pe_word_t a, input pe_word_t b);
  case (op)
    ADD:     return a + b;
    SUB:     return a - b;
    // Low half only
    MUL:     return a * b;
    MIN:     return (a < b) ? a : b;
    DIV:     return (b == '0) ? '1 : a / b;
    REM:     return (b == '0) ? a : a % b;
    default: return '0;
  endcase
endfunction

// Word that the delay register takes at an accepted edge
function automatic pe_delay_t ref_delay(
  input delay_src_t src,
  input logic       div_op,
  input pe_delay_t  nd,
  input pe_stream_t res,
  input pe_stream_t op_a,
  input pe_stream_t op_b,
  input pe_word_t   rem,
  input logic       done
);
  pe_delay_t d;
  // Side bit rides along from the chosen neighbor
  d.side = nd.side;
  case (src)
    D_PE_RES: begin
      d.data  = div_op ? rem : res.data;
      d.valid = div_op ? done : res.valid;
    end
    D_PE_OP_A: begin
      d.data  = op_a.data;
      d.valid = op_a.valid;
    end
    D_PE_OP_B: begin
      d.data  = op_b.data;
      d.valid = op_b.valid;
    end
    default: begin
      d.data  = nd.data;
      d.valid = nd.valid;
    end
  endcase
  return d;
endfunction

// Stream capture fires on a valid NEIGH0 word at the chosen count
function automatic logic ref_rf_hit(
  input logic [RF_CNT_W-1:0] cnt,
  input logic [1:0]          rf_val,
  input logic                word_valid
);
  return word_valid && (cnt == rf_val);
endfunction

`endif

// File: testbench/tb_s_pe.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the streaming PE, N_NEIGH fixed at 4
// Inputs change on the rising edge, outputs are sampled on the falling
// A cycle model tracks result, delay, divider and capture counter
//////////////////////////////////////////////////////////////////////

module tb_s_pe
  import pe_cfg_pkg::*;
  import pe_data_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  `include "tb_pe_ref.svh"

  localparam int          N_NEIGH    = 4;
  localparam int          MAX_CYCLES = 10000;
  localparam int unsigned SEED       = 32'h812d_a6bc;

  logic                     clk_cg;
  logic                     rst_n_i;
  logic                     flush_i;
  logic                     pea_ready_i;
  pe_ctrl_t                 ctrl_i;
  pe_stream_t [N_NEIGH-1:0] neigh_i;
  pe_word_t                 const_i;
  pe_word_t                 rf_d_i;
  logic [RF_CNT_W-1:0]      rf_match_i;
  pe_delay_t [N_NEIGH-1:0]  neigh_delay_i;
  pe_stream_t               res_o;
  logic                     ready_o;
  rf_wr_t                   rf_wr_o;
  pe_delay_t                delay_o;

  // Model state, valid right after each rising edge
  pe_stream_t          res_m;
  pe_delay_t           del_m;
  int                  div_left;
  pe_word_t            div_a;
  pe_word_t            div_b;
  logic [RF_CNT_W-1:0] cnt_m;
  // Stimulus knobs in percent
  int                  ready_pct;
  int                  flush_pct;
  int                  cycles = 0;

  s_pe #(
    .N_NEIGH (N_NEIGH)
  ) uut (
    .clk_cg        (clk_cg),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .pea_ready_i   (pea_ready_i),
    .ctrl_i        (ctrl_i),
    .neigh_i       (neigh_i),
    .const_i       (const_i),
    .rf_d_i        (rf_d_i),
    .rf_match_i    (rf_match_i),
    .neigh_delay_i (neigh_delay_i),
    .res_o         (res_o),
    .ready_o       (ready_o),
    .rf_wr_o       (rf_wr_o),
    .delay_o       (delay_o)
  );

  initial begin
    clk_cg = 1'b0;
    forever #10 clk_cg = ~clk_cg;
  end

  // Run limit, about twice the total phase length
  always @(posedge clk_cg) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "Cycle limit reached");
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Zero and small values show up often, for divide by zero
  function automatic pe_word_t rand_word();
    int r;
    r = $urandom_range(7);
    if (r == 0) return '0;
    if (r < 3) return pe_word_t'($urandom_range(15));
    return pe_word_t'($urandom);
  endfunction

  function automatic pe_ctrl_t make_ctrl(input pe_op_t op, input pe_mux_sel_t sa,
                                         input pe_mux_sel_t sb, input delay_src_t dsrc,
                                         input logic rf_en, input rf_src_t rsrc);
    pe_ctrl_t c;
    c.op        = op;
    c.sel_a     = sa;
    c.sel_b     = sb;
    c.rf_en     = rf_en;
    c.rf_src    = rsrc;
    c.rf_val    = 2'($urandom_range(3));
    c.delay_sel = 2'($urandom_range(3));
    c.delay_src = dsrc;
    return c;
  endfunction

  task automatic drive_cycle();
    @(posedge clk_cg);
    pea_ready_i <= ($urandom_range(99) < ready_pct);
    flush_i     <= ($urandom_range(99) < flush_pct);
    const_i     <= rand_word();
    rf_d_i      <= rand_word();
    for (int i = 0; i < N_NEIGH; i++) begin
      neigh_i[i]       <= '{data: rand_word(), valid: ($urandom_range(3) != 0)};
      neigh_delay_i[i] <= '{side: 1'($urandom_range(1)), data: rand_word(),
                             valid: 1'($urandom_range(1))};
    end
  endtask

  // New static config, flushed once so no division spans two phases
  task automatic run_phase(input pe_ctrl_t ctrl, input int n, input int rdy, input int fl);
    @(posedge clk_cg);
    ctrl_i     <= ctrl;
    rf_match_i <= RF_CNT_W'($urandom_range(3));
    flush_i    <= 1'b1;
    ready_pct = rdy;
    flush_pct = fl;
    repeat (n) drive_cycle();
  endtask

  // Operand as the selection rules define it
  function automatic pe_stream_t pick_operand(input pe_mux_sel_t sel);
    pe_delay_t nd;
    nd = neigh_delay_i[ctrl_i.delay_sel];
    case (sel)
      SELF:     return '{data: res_m.data, valid: 1'b1};
      CONST:    return '{data: const_i, valid: 1'b1};
      RF_IN:    return '{data: rf_d_i, valid: 1'b1};
      DELAY_OP: return '{data: nd.data, valid: nd.valid};
      default:  return neigh_i[int'(sel)];
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_cg) begin : compare_outputs
    pe_stream_t a;
    pe_stream_t b;
    pe_delay_t  nd;
    rf_wr_t     exp_wr;
    logic       is_div;
    logic       done_now;
    pe_word_t   fu_data;
    if (!rst_n_i) begin
      res_m    = '0;
      del_m    = '0;
      div_left = 0;
      cnt_m    = '0;
    end else begin
      a  = pick_operand(ctrl_i.sel_a);
      b  = pick_operand(ctrl_i.sel_b);
      nd = neigh_delay_i[ctrl_i.delay_sel];
      // Registered outputs, also the state right after reset
      check_value(res_o, res_m, "res_o");
      check_value(delay_o.valid, del_m.valid, "delay_o.valid");
      if (del_m.valid) begin
        check_value(delay_o, del_m, "delay_o");
      end
      check_value(ready_o, div_left == 0, "ready_o");
      // Register-file port is combinational
      exp_wr = '0;
      if (ctrl_i.rf_en && pea_ready_i) begin
        case (ctrl_i.rf_src)
          RF_STREAM: exp_wr = '{en: ref_rf_hit(cnt_m, ctrl_i.rf_val, neigh_i[0].valid),
                                data: neigh_i[0].data};
          RF_OP_A:   exp_wr = '{en: a.valid, data: a.data};
          RF_OP_B:   exp_wr = '{en: b.valid, data: b.data};
          default:   exp_wr = '0;
        endcase
      end
      check_value(rf_wr_o.en, exp_wr.en, "rf_wr_o.en");
      if (exp_wr.en) begin
        check_value(rf_wr_o.data, exp_wr.data, "rf_wr_o.data");
      end
      // Next-state prediction
      is_div   = (ctrl_i.op == DIV) || (ctrl_i.op == REM);
      done_now = (div_left == 1) && pea_ready_i && !flush_i;
      fu_data  = is_div ? ref_fu(ctrl_i.op, div_a, div_b) : ref_fu(ctrl_i.op, a.data, b.data);
      // Delay uses the result before this edge
      if (flush_i) begin
        del_m = '0;
      end else if (pea_ready_i) begin
        del_m = ref_delay(ctrl_i.delay_src, is_div, nd, res_m, a, b,
                          ref_fu(REM, div_a, div_b), done_now);
      end
      if (flush_i || (ctrl_i.op == NOP)) begin
        res_m = '0;
      end else if (pea_ready_i) begin
        res_m.valid = is_div ? done_now : (a.valid && b.valid);
        if (res_m.valid) begin
          res_m.data = fu_data;
        end
      end
      // Divider occupancy in advancing cycles
      if (flush_i) begin
        div_left = 0;
      end else if (pea_ready_i) begin
        if (is_div && a.valid && b.valid && (div_left == 0)) begin
          div_left = PE_DATA_W;
          div_a    = a.data;
          div_b    = b.data;
        end else if (div_left > 0) begin
          div_left = div_left - 1;
        end
      end
      if (ctrl_i.rf_en && pea_ready_i && neigh_i[0].valid) begin
        cnt_m = (cnt_m == rf_match_i) ? '0 : cnt_m + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int seed_val;
    seed_val      = $urandom(SEED);
    rst_n_i       = 1'b0;
    flush_i       = 1'b0;
    pea_ready_i   = 1'b1;
    ctrl_i        = '0;
    neigh_i       = '0;
    const_i       = '0;
    rf_d_i        = '0;
    rf_match_i    = '0;
    neigh_delay_i = '0;
    ready_pct     = 100;
    flush_pct     = 0;
    repeat (8) @(posedge clk_cg);
    rst_n_i <= 1'b1;
    // Single-cycle ops, one delay source each
    run_phase(make_ctrl(ADD, NEIGH0, NEIGH1, D_PE_RES, 1'b0, RF_STREAM), 150, 100, 0);
    run_phase(make_ctrl(SUB, NEIGH2, CONST, D_PE_OP_A, 1'b0, RF_STREAM), 150, 100, 0);
    run_phase(make_ctrl(MUL, NEIGH3, RF_IN, D_PE_OP_B, 1'b0, RF_STREAM), 150, 100, 0);
    run_phase(make_ctrl(MIN, SELF, NEIGH0, D_PE_DELAY_OP, 1'b0, RF_STREAM), 150, 100, 0);
    run_phase(make_ctrl(ADD, DELAY_OP, SELF, D_PE_RES, 1'b0, RF_STREAM), 150, 100, 0);
    // Division, remainder goes out on the delay path
    run_phase(make_ctrl(DIV, NEIGH0, NEIGH1, D_PE_RES, 1'b0, RF_STREAM), 700, 100, 0);
    run_phase(make_ctrl(REM, NEIGH1, CONST, D_PE_RES, 1'b0, RF_STREAM), 700, 100, 0);
    // Back-pressure
    run_phase(make_ctrl(DIV, NEIGH2, NEIGH3, D_PE_RES, 1'b0, RF_STREAM), 700, 60, 0);
    run_phase(make_ctrl(ADD, NEIGH0, NEIGH1, D_PE_OP_A, 1'b0, RF_STREAM), 300, 50, 0);
    // Register-file capture
    repeat (4) begin
      run_phase(make_ctrl(ADD, NEIGH0, CONST, D_PE_RES, 1'b1, RF_STREAM), 150, 80, 0);
    end
    run_phase(make_ctrl(MUL, NEIGH1, NEIGH2, D_PE_OP_B, 1'b1, RF_OP_A), 200, 80, 0);
    run_phase(make_ctrl(MIN, CONST, NEIGH3, D_PE_OP_A, 1'b1, RF_OP_B), 200, 80, 0);
    // NOP and random flush pulses
    run_phase(make_ctrl(NOP, NEIGH0, NEIGH1, D_PE_DELAY_OP, 1'b0, RF_STREAM), 150, 80, 0);
    run_phase(make_ctrl(ADD, NEIGH1, NEIGH2, D_PE_RES, 1'b0, RF_STREAM), 300, 80, 10);
    run_phase(make_ctrl(REM, NEIGH3, NEIGH0, D_PE_RES, 1'b0, RF_STREAM), 600, 80, 5);
    // Let the last prediction be compared
    @(posedge clk_cg);
    @(negedge clk_cg);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+testbench
logic/pe_cfg_pkg.sv
logic/pe_data_pkg.sv
logic/pe_operand_select.sv
logic/pe_divider.sv
logic/pe_fu.sv
logic/pe_delay_path.sv
logic/s_pe.sv
testbench/tb_s_pe.sv
